//--- source/stepper_pkg.sv
package stepper_pkg;

  localparam int CMD_ARG_W = 24;  // Argument field of a command word
  localparam int PHASE_W   = 5;   // 32-entry electrical phase index

  // Command opcodes in the top byte of a word
  typedef enum logic [7:0] {
    OP_MOVE_FWD  = 8'd1,
    OP_MOVE_REV  = 8'd2,
    OP_SET_DIV   = 8'd3,
    OP_SET_USTEP = 8'd4,
    OP_STOP      = 8'd5
  } opcode_t;

  typedef struct packed {
    opcode_t              op;
    logic [CMD_ARG_W-1:0] arg;
  } cmd_word_t;

  typedef struct packed {
    logic [CMD_ARG_W-1:0] divisor;    // Clock cycles per step
    logic [1:0]           ustep_exp;  // log2 of microsteps per full step
  } motor_cfg_t;

  typedef struct packed {
    logic step;  // One-cycle pulse
    logic dir;   // Forward when set
  } step_evt_t;

  // H-bridge polarities and PWM enables
  typedef struct packed {
    logic a1;
    logic a2;
    logic b1;
    logic b2;
    logic pwm_a;
    logic pwm_b;
  } coil_drive_t;

endpackage

//--- source/spi_slave.sv
module spi_slave #(
  parameter int SYNC_STAGES = 3
) (
  input  logic       CLK,
  input  logic       rst_n,
  input  logic       sck,
  input  logic       ssel,
  input  logic       mosi,
  input  logic [7:0] tx_byte,
  output logic       miso,
  output logic       byte_valid,
  output logic [7:0] rx_byte
);

  logic [SYNC_STAGES:0]   sck_q;  // Top stage holds the previous level
  logic [SYNC_STAGES-1:0] ssel_q;
  logic [SYNC_STAGES-1:0] mosi_q;
  logic                   sck_rise;
  logic                   sck_fall;
  logic                   ssel_s;
  logic                   mosi_s;
  logic [2:0]             bit_cnt;
  logic [7:0]             rx_shift;
  logic [7:0]             tx_shift;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      sck_q  <= '0;
      ssel_q <= '1;  // Deselected
      mosi_q <= '0;
    end else begin
      sck_q  <= {sck_q[SYNC_STAGES-1:0], sck};
      ssel_q <= {ssel_q[SYNC_STAGES-2:0], ssel};
      mosi_q <= {mosi_q[SYNC_STAGES-2:0], mosi};
    end
  end

  assign sck_rise = sck_q[SYNC_STAGES-1] & ~sck_q[SYNC_STAGES];
  assign sck_fall = ~sck_q[SYNC_STAGES-1] & sck_q[SYNC_STAGES];
  assign ssel_s   = ssel_q[SYNC_STAGES-1];
  assign mosi_s   = mosi_q[SYNC_STAGES-1];

  // Mode 0: sample on rising, shift out on falling
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      bit_cnt    <= '0;
      byte_valid <= 1'b0;
      tx_shift   <= '0;
    end else begin
      byte_valid <= 1'b0;
      if (ssel_s) begin
        bit_cnt  <= '0;       // Partial byte is dropped
        tx_shift <= tx_byte;  // MSB ready before the first edge
      end else if (sck_rise) begin
        bit_cnt    <= bit_cnt + 3'd1;
        byte_valid <= (bit_cnt == 3'd7);
      end else if (sck_fall) begin
        if (bit_cnt == 3'd0) begin
          tx_shift <= tx_byte;  // Start of the next byte
        end else begin
          tx_shift <= {tx_shift[6:0], 1'b0};
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (!ssel_s && sck_rise) begin
      rx_shift <= {rx_shift[6:0], mosi_s};
    end
  end

  assign rx_byte = rx_shift;
  assign miso    = tx_shift[7];

  // A completed byte must come from a selected transfer
  assert property (@(posedge CLK) disable iff (!rst_n) $rose(byte_valid) |-> !ssel)
    else $error("byte_valid raised while SSEL inactive");

endmodule

//--- source/word_assembler.sv
module word_assembler (
  input  logic                   CLK,
  input  logic                   rst_n,
  input  logic                   byte_valid,
  input  logic [7:0]             rx_byte,
  input  logic                   ssel,
  output logic                   word_valid,
  output stepper_pkg::cmd_word_t word,
  output logic [7:0]             tx_byte
);

  logic [1:0]  ssel_q;  // Pin arrives asynchronously
  logic [1:0]  byte_cnt;
  logic [31:0] word_sr;
  logic [31:0] reply;   // Last full word, echoed back

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      ssel_q     <= '1;
      byte_cnt   <= '0;
      word_valid <= 1'b0;
      reply      <= '0;
    end else begin
      ssel_q     <= {ssel_q[0], ssel};
      word_valid <= 1'b0;
      if (word_valid) begin
        reply <= word_sr;
      end
      if (ssel_q[1]) begin
        byte_cnt <= '0;
      end else if (byte_valid) begin
        byte_cnt   <= byte_cnt + 2'd1;
        word_valid <= (byte_cnt == 2'd3);
      end
    end
  end

  // Little endian, first byte ends up in [7:0]
  always_ff @(posedge CLK) begin
    if (byte_valid) begin
      word_sr <= {rx_byte, word_sr[31:8]};
    end
  end

  assign word    = stepper_pkg::cmd_word_t'(word_sr);
  assign tx_byte = reply[8*byte_cnt +: 8];

endmodule

//--- source/motion_ctrl.sv
module motion_ctrl #(
  parameter int DIV_RESET = 3072
) (
  input  logic                    CLK,
  input  logic                    rst_n,
  input  logic                    word_valid,
  input  stepper_pkg::cmd_word_t  word,
  input  logic                    step_tick,
  output stepper_pkg::motor_cfg_t cfg,
  output logic                    run,
  output logic                    busy,
  output stepper_pkg::step_evt_t  evt
);

  logic [stepper_pkg::CMD_ARG_W-1:0] remaining;  // Steps left in the move
  logic                              dir;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      cfg.divisor   <= DIV_RESET[stepper_pkg::CMD_ARG_W-1:0];
      cfg.ustep_exp <= 2'd0;  // Full steps
      run           <= 1'b0;
      remaining     <= '0;
      dir           <= 1'b1;
    end else begin
      if (step_tick && run) begin
        remaining <= remaining - 1'b1;
        if (remaining == 1) begin
          run <= 1'b0;  // Last step issued
        end
      end
      // A command in the same cycle overrides the tick update
      if (word_valid) begin
        case (word.op)
          stepper_pkg::OP_MOVE_FWD, stepper_pkg::OP_MOVE_REV: begin
            if (word.arg != '0) begin
              remaining <= word.arg;
              dir       <= (word.op == stepper_pkg::OP_MOVE_FWD);
              run       <= 1'b1;
            end
          end
          stepper_pkg::OP_SET_DIV: cfg.divisor <= word.arg;
          stepper_pkg::OP_SET_USTEP: begin
            if (word.arg < 4) begin
              cfg.ustep_exp <= word.arg[1:0];
            end
          end
          stepper_pkg::OP_STOP: begin
            run       <= 1'b0;
            remaining <= '0;
          end
          default: ;  // Unknown opcodes ignored
        endcase
      end
    end
  end

  assign busy     = run;
  assign evt.step = step_tick & run;
  assign evt.dir  = dir;

  assert property (@(posedge CLK) disable iff (!rst_n) evt.step |-> remaining != '0)
    else $error("Step event outside a move");

endmodule

//--- source/step_timer.sv
module step_timer (
  input  logic        CLK,
  input  logic        rst_n,
  input  logic        run,
  input  logic [23:0] divisor,
  output logic        step_tick
);

  logic [23:0] count;
  logic [23:0] div_eff;  // Zero behaves as one

  assign div_eff = (divisor == 24'd0) ? 24'd1 : divisor;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      count     <= '0;
      step_tick <= 1'b0;
    end else if (!run) begin
      count     <= '0;
      step_tick <= 1'b0;
    end else if (count >= div_eff - 24'd1) begin
      // Also catches a divisor lowered mid-move
      count     <= '0;
      step_tick <= 1'b1;
    end else begin
      count     <= count + 24'd1;
      step_tick <= 1'b0;
    end
  end

  // Ticks are spaced by the divisor, so back-to-back only at divisor 1
  assert property (@(posedge CLK) disable iff (!rst_n)
    step_tick && divisor > 24'd1 ##1 divisor > 24'd1 |-> !step_tick)
    else $error("Consecutive step ticks with divisor above 1");

endmodule

//--- source/phase_driver.sv
module phase_driver #(
  parameter int PWM_W = 6
) (
  input  logic                     CLK,
  input  logic                     rst_n,
  input  stepper_pkg::step_evt_t   evt,
  input  logic [1:0]               ustep_exp,
  output stepper_pkg::coil_drive_t coils
);

  localparam int PW = stepper_pkg::PHASE_W;

  // Rising quarter sine, 8-bit full scale
  localparam logic [7:0] SINE_LUT [8] = '{
    8'd0, 8'd50, 8'd98, 8'd142, 8'd180, 8'd212, 8'd236, 8'd250
  };

  logic [PW-1:0]    index;
  logic [PW-1:0]    delta;  // 8 index counts per full step
  logic [2:0]       fine;
  logic [PWM_W-1:0] pwm_cnt;
  logic [PWM_W-1:0] duty_a;
  logic [PWM_W-1:0] duty_b;

  assign delta = PW'(8) >> ustep_exp;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      index   <= '0;
      pwm_cnt <= '0;
    end else begin
      pwm_cnt <= pwm_cnt + PWM_W'(1);  // Free running
      if (evt.step) begin
        index <= evt.dir ? index + delta : index - delta;  // Wraps mod 32
      end
    end
  end

  assign fine   = index[2:0];
  assign duty_a = SINE_LUT[~fine][7 -: PWM_W];  // Falling half
  assign duty_b = SINE_LUT[fine][7 -: PWM_W];

  always_comb begin
    coils = '0;
    case (index[PW-1 -: 2])
      2'd0: begin
        coils.a1 = 1'b1;
        coils.b1 = 1'b1;
      end
      2'd1: begin
        coils.a2 = 1'b1;
        coils.b1 = 1'b1;
      end
      2'd2: begin
        coils.a2 = 1'b1;
        coils.b2 = 1'b1;
      end
      default: begin
        coils.a1 = 1'b1;
        coils.b2 = 1'b1;
      end
    endcase
    coils.pwm_a = (pwm_cnt < duty_a);
    coils.pwm_b = (pwm_cnt < duty_b);
  end

endmodule

//--- source/stepper_top.sv
module stepper_top #(
  parameter int SYNC_STAGES = 3,
  parameter int PWM_W       = 6,
  parameter int DIV_RESET   = 3072
) (
  input  logic                     CLK,
  input  logic                     rst_n,
  input  logic                     sck,
  input  logic                     ssel,
  input  logic                     mosi,
  output logic                     miso,
  output logic                     busy,
  output stepper_pkg::coil_drive_t coils,
  output logic                     step_out
);

  logic                    byte_valid;
  logic [7:0]              rx_byte;
  logic [7:0]              tx_byte;  // Echo byte back to the slave
  logic                    word_valid;
  stepper_pkg::cmd_word_t  word;
  stepper_pkg::motor_cfg_t cfg;
  logic                    run;
  logic                    step_tick;
  stepper_pkg::step_evt_t  evt;

  spi_slave #(.SYNC_STAGES(SYNC_STAGES)) spi_slave_inst (
    .CLK, .rst_n, .sck, .ssel, .mosi, .tx_byte, .miso, .byte_valid, .rx_byte
  );

  word_assembler word_assembler_inst (
    .CLK, .rst_n, .byte_valid, .rx_byte, .ssel, .word_valid, .word, .tx_byte
  );

  motion_ctrl #(.DIV_RESET(DIV_RESET)) motion_ctrl_inst (
    .CLK, .rst_n, .word_valid, .word, .step_tick, .cfg, .run, .busy, .evt
  );

  step_timer step_timer_inst (
    .CLK,
    .rst_n,
    .run,
    .divisor   (cfg.divisor),
    .step_tick
  );

  phase_driver #(.PWM_W(PWM_W)) phase_driver_inst (
    .CLK,
    .rst_n,
    .evt,
    .ustep_exp (cfg.ustep_exp),
    .coils
  );

  assign step_out = evt.step;  // Debug pin

endmodule

//--- verification/tb_stepper_top.sv
module tb_stepper_top;

  localparam int HALF_SCK       = 8;      // CLK cycles per SCK half-period
  localparam int TIMEOUT_CYCLES = 20000;  // Twice 13 word transfers plus the moves
  localparam int PWM_PERIOD     = 64;     // Cycles in one PWM period

  logic                     CLK;
  logic                     rst_n;
  logic                     sck;
  logic                     ssel;
  logic                     mosi;
  logic                     miso;
  logic                     busy;
  stepper_pkg::coil_drive_t coils;
  logic                     step_out;

  logic [31:0] rng;
  logic [31:0] prev_word;  // Expected echo
  logic        busy_d;
  logic        model_dir;
  logic [1:0]  model_ustep;
  logic [4:0]  model_idx;  // Phase index from the commanded moves
  logic [4:0]  step_size;
  logic [3:0]  exp_coils;
  logic [3:0]  act_coils;
  logic        count_en;
  logic        stop_sent;
  int          exp_steps;
  int          exp_div;
  int          pulses;
  int          gap;
  int          pwm_win;  // Cycles with a steady phase index
  int          hi_a;
  int          hi_b;
  int          moves_done;
  int          cycles;
  int          count_errs;
  int          gap_errs;
  int          coil_errs;
  int          duty_errs;
  int          stop_errs;
  int          echo_errs;

  stepper_top stepper_top_inst (
    .CLK, .rst_n, .sck, .ssel, .mosi, .miso, .busy, .coils, .step_out
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Bridge polarities {a1, a2, b1, b2} per quadrant
  function automatic logic [3:0] coil_pattern(input logic [1:0] quad);
    case (quad)
      2'd0:    return 4'b1010;
      2'd1:    return 4'b0110;
      2'd2:    return 4'b0101;
      default: return 4'b1001;
    endcase
  endfunction

  assign step_size = 5'(1 << (3 - model_ustep));
  assign exp_coils = coil_pattern(model_idx[4:3]);
  assign act_coils = {coils.a1, coils.a2, coils.b1, coils.b2};

  always @(posedge CLK) begin
    if (!rst_n) begin
      busy_d     <= 1'b0;
      pulses     <= 0;
      gap        <= 0;
      pwm_win    <= 0;
      hi_a       <= 0;
      hi_b       <= 0;
      moves_done <= 0;
      model_idx  <= '0;
    end else begin
      busy_d <= busy;
      if (busy && !busy_d) begin
        pulses <= 0;
      end else if (step_out) begin
        pulses <= pulses + 1;
      end
      if (!busy) begin
        gap <= 0;  // Counts from the start of the move
      end else if (step_out) begin
        gap <= 1;
      end else begin
        gap <= gap + 1;
      end
      if (step_out || pwm_win == PWM_PERIOD) begin
        pwm_win <= 0;  // New duty window
        hi_a    <= 0;
        hi_b    <= 0;
      end else begin
        pwm_win <= pwm_win + 1;
        hi_a    <= hi_a + int'(coils.pwm_a);
        hi_b    <= hi_b + int'(coils.pwm_b);
      end
      if (busy_d && !busy) begin
        moves_done <= moves_done + 1;
      end
      if (step_out) begin
        model_idx <= model_dir ? model_idx + step_size : model_idx - step_size;
      end
    end
  end

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation FAILED");
      $finish;
    end
  end

  assert property (@(posedge CLK) disable iff (!rst_n)
    $fell(busy) && count_en |-> pulses == exp_steps)
    else begin
      count_errs++;
      $display("ERROR step_count: expected %0d, actual %0d", exp_steps, $sampled(pulses));
    end

  assert property (@(posedge CLK) disable iff (!rst_n) step_out |-> gap == exp_div)
    else begin
      gap_errs++;
      $display("ERROR step_spacing: expected %0d, actual %0d", exp_div, $sampled(gap));
    end

  assert property (@(posedge CLK) disable iff (!rst_n) act_coils == exp_coils)
    else begin
      coil_errs++;
      $display("ERROR coil_sequence: expected %b, actual %b",
               $sampled(exp_coils), $sampled(act_coils));
    end

  // Coil A runs down the duty table while coil B runs up it
  assert property (@(posedge CLK) disable iff (!rst_n)
    pwm_win == PWM_PERIOD |-> (model_idx[2] ? hi_b > hi_a : hi_a > hi_b))
    else begin
      duty_errs++;
      $display("ERROR pwm_duty: expected coil %s ahead, actual A %0d B %0d",
               $sampled(model_idx[2]) ? "B" : "A", $sampled(hi_a), $sampled(hi_b));
    end

  assert property (@(posedge CLK) disable iff (!rst_n) stop_sent |-> !busy && !step_out)
    else begin
      stop_errs++;
      $display("Motor still busy or stepping after the stop command");
    end

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge CLK);
  endtask

  // Mode 0, LSB byte first, MSB first in each byte
  task automatic send_word(input logic [31:0] w);
    logic [31:0] echo;
    echo = '0;
    @(posedge CLK);
    ssel <= 1'b0;
    for (int b = 0; b < 4; b++) begin
      for (int i = 7; i >= 0; i--) begin
        sck  <= 1'b0;
        mosi <= w[8*b+i];
        wait_cycles(HALF_SCK);
        echo[8*b+i] = miso;  // Stable for a half-period
        sck <= 1'b1;
        wait_cycles(HALF_SCK);
      end
    end
    sck <= 1'b0;
    wait_cycles(HALF_SCK);
    ssel <= 1'b1;
    wait_cycles(HALF_SCK);
    assert (echo == prev_word) else begin
      echo_errs++;
      $display("ERROR echo: expected %08h, actual %08h", prev_word, echo);
    end
    prev_word = w;
  endtask

  task automatic set_divisor(input int d);
    send_word({stepper_pkg::OP_SET_DIV, 24'(d)});
    exp_div = d;
  endtask

  task automatic set_ustep(input int e);
    send_word({stepper_pkg::OP_SET_USTEP, 24'(e)});
    if (e <= 3) begin
      model_ustep = 2'(e);  // Larger values are ignored
    end
  endtask

  task automatic do_move(input logic fwd, input int n);
    int target;
    target    = moves_done + 1;
    model_dir = fwd;
    exp_steps = n;
    send_word({fwd ? stepper_pkg::OP_MOVE_FWD : stepper_pkg::OP_MOVE_REV, 24'(n)});
    while (moves_done < target) @(posedge CLK);
  endtask

  initial begin
    int n;
    int d;
    rst_n = 1'b0;
    sck = 1'b0;
    ssel = 1'b1;
    mosi = 1'b0;
    rng = 32'h9b1a4c4c;
    prev_word = '0;
    model_dir = 1'b1;
    model_ustep = 2'd0;
    count_en = 1'b1;
    stop_sent = 1'b0;
    exp_steps = 0;
    exp_div = 3072;
    cycles = 0;
    count_errs = 0;
    gap_errs = 0;
    coil_errs = 0;
    duty_errs = 0;
    stop_errs = 0;
    echo_errs = 0;
    repeat (2) @(posedge CLK);
    rst_n <= 1'b1;
    wait_cycles(4);
    // Full steps, forward then reverse then forward
    for (int k = 0; k < 3; k++) begin
      rng = lcg_next(rng);
      n   = 1 + int'(rng[30:24]) % 20;
      d   = 2 + int'(rng[22:16]) % 39;
      set_divisor(d);
      do_move(k != 1, n);
    end
    set_ustep(3);
    do_move(1'b1, 8);  // One quadrant in eighth steps
    set_ustep(4);
    do_move(1'b0, 8);
    set_divisor(40);
    count_en = 1'b0;  // Stopped move ends short
    model_dir = 1'b1;
    send_word({stepper_pkg::OP_MOVE_FWD, 24'd20});
    assert (busy) else begin
      stop_errs++;
      $display("Long move was not running when the stop command was sent");
    end
    send_word({stepper_pkg::OP_STOP, 24'd0});
    stop_sent = 1'b1;
    wait_cycles(3 * 40);
    $display("Errors: step count %0d, spacing %0d, coils %0d, duty %0d, stop %0d, echo %0d",
             count_errs, gap_errs, coil_errs, duty_errs, stop_errs, echo_errs);
    if (count_errs + gap_errs + coil_errs + duty_errs + stop_errs + echo_errs == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- tb.f
source/stepper_pkg.sv
source/spi_slave.sv
source/word_assembler.sv
source/motion_ctrl.sv
source/step_timer.sv
source/phase_driver.sv
source/stepper_top.sv
verification/tb_stepper_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f tb.f --top-module tb_stepper_top -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or run error"; exit 1; }
cat sim.log
grep -q "Simulation PASSED" sim.log && exit 0 || exit 1
